//--- red_cfg.svh
`ifndef RED_CFG_SVH
`define RED_CFG_SVH

// one vector register.
`define RED_VLEN 128

// largest register group.
`define RED_NREGS 4

// scalar operand and result.
`define RED_XLEN 32

// working register is half of a full group.
`define RED_WORK_BITS 256

// level counter for levels 0 to 5.
`define RED_STEP_BITS 3

`endif

//--- red_pkg.sv
`include "red_cfg.svh"

package red_pkg;

    // codes above OP_MAX mean idle.
    typedef enum logic [2:0] {
        OP_IDLE = 3'd0,
        OP_SUM  = 3'd1,
        OP_MAX  = 3'd2
    } red_op_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } red_sew_e;

    typedef enum logic [1:0] {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2
    } red_lmul_e;

    typedef struct packed {
        red_op_e   op;
        red_sew_e  sew;
        red_lmul_e lmul;
    } red_cfg_t;

    // register 1 sits in the low bits.
    typedef struct packed {
        logic [`RED_VLEN-1:0] v4;
        logic [`RED_VLEN-1:0] v3;
        logic [`RED_VLEN-1:0] v2;
        logic [`RED_VLEN-1:0] v1;
    } red_src_t;

    typedef union packed {
        logic [`RED_WORK_BITS/8-1:0][7:0]   b;
        logic [`RED_WORK_BITS/16-1:0][15:0] h;
        logic [`RED_WORK_BITS/32-1:0][31:0] w;
    } red_work_t;

    // log2 of the element count (2 to 6).
    function automatic logic [`RED_STEP_BITS-1:0] red_levels(input red_cfg_t cfg);
        return 3'd4 - {1'b0, cfg.sew} + {1'b0, cfg.lmul};
    endfunction

    function automatic logic [`RED_XLEN-1:0] red_sext(input red_sew_e sew,
                                                      input logic [`RED_XLEN-1:0] x);
        case (sew)
            SEW_8:   return {{(`RED_XLEN-8){x[7]}}, x[7:0]};
            SEW_16:  return {{(`RED_XLEN-16){x[15]}}, x[15:0]};
            default: return x;
        endcase
    endfunction

    function automatic logic [`RED_XLEN-1:0] red_zext(input red_sew_e sew,
                                                      input logic [`RED_XLEN-1:0] x);
        case (sew)
            SEW_8:   return {{(`RED_XLEN-8){1'b0}}, x[7:0]};
            SEW_16:  return {{(`RED_XLEN-16){1'b0}}, x[15:0]};
            default: return x;
        endcase
    endfunction

    // filler for dead lanes. only the low element bits count.
    function automatic logic [`RED_XLEN-1:0] red_identity(input red_op_e op,
                                                          input red_sew_e sew);
        if (op != OP_MAX)
            return '0;
        case (sew)
            SEW_8:   return 32'h0000_0080;
            SEW_16:  return 32'h0000_8000;
            default: return 32'h8000_0000;
        endcase
    endfunction

    // operands come sign-extended. a wins a max tie.
    function automatic logic [`RED_XLEN-1:0] red_combine(input red_op_e op,
                                                         input logic [`RED_XLEN-1:0] a,
                                                         input logic [`RED_XLEN-1:0] b);
        if (op == OP_MAX)
            return ($signed(a) >= $signed(b)) ? a : b;
        return a + b;
    endfunction

endpackage

//--- red_tree_level.sv
`timescale 1ns/10ps
`include "red_cfg.svh"

module red_tree_level #(
    parameter int in_bits = 512
) (
    input  red_pkg::red_cfg_t          cfg,
    input  logic [`RED_STEP_BITS-1:0]  level,
    input  logic [in_bits-1:0]         word_in,
    output red_pkg::red_work_t         word_out
);

    import red_pkg::*;

    logic [2*`RED_WORK_BITS-1:0] ext;
    logic [6:0]                  n_elems;
    logic [6:0]                  live;
    logic [`RED_XLEN-1:0]        ident;
    logic [`RED_XLEN-1:0]        lo;
    logic [`RED_XLEN-1:0]        hi;
    logic [`RED_XLEN-1:0]        res;

    always_comb
    begin
        ext = '0;
        ext[in_bits-1:0] = word_in;
        n_elems = 7'd1 << red_levels(cfg);
        live = n_elems >> (level + 1'b1); // pairs still holding data.
        ident = red_identity(cfg.op, cfg.sew);
        word_out = '0;
        lo = '0;
        hi = '0;
        res = '0;

        case (cfg.sew)
            SEW_8:
            begin
                for (int i = 0; i < `RED_WORK_BITS/8; i++)
                begin
                    lo = red_sext(cfg.sew, {{(`RED_XLEN-8){1'b0}}, ext[16*i +: 8]});
                    hi = red_sext(cfg.sew, {{(`RED_XLEN-8){1'b0}}, ext[16*i+8 +: 8]});
                    res = (i < live) ? red_combine(cfg.op, lo, hi) : ident;
                    word_out.b[i] = res[7:0];
                end
            end
            SEW_16:
            begin
                for (int i = 0; i < `RED_WORK_BITS/16; i++)
                begin
                    lo = red_sext(cfg.sew, {{(`RED_XLEN-16){1'b0}}, ext[32*i +: 16]});
                    hi = red_sext(cfg.sew, {{(`RED_XLEN-16){1'b0}}, ext[32*i+16 +: 16]});
                    res = (i < live) ? red_combine(cfg.op, lo, hi) : ident;
                    word_out.h[i] = res[15:0];
                end
            end
            default:
            begin
                for (int i = 0; i < `RED_WORK_BITS/32; i++)
                begin
                    lo = ext[64*i +: 32];
                    hi = ext[64*i+32 +: 32];
                    res = (i < live) ? red_combine(cfg.op, lo, hi) : ident;
                    word_out.w[i] = res;
                end
            end
        endcase
    end

endmodule

//--- red_seq.sv
`timescale 1ns/10ps
`include "red_cfg.svh"

module red_seq (
    input  logic                       clk,
    input  logic                       nrst,
    input  red_pkg::red_cfg_t          cfg,
    output logic [`RED_STEP_BITS-1:0]  level,
    output logic                       busy,
    output logic                       last,
    output logic                       done
);

    import red_pkg::*;

    logic [`RED_STEP_BITS-1:0] n_levels;
    logic                      op_valid;
    logic                      start;
    logic                      active;

    assign n_levels = red_levels(cfg);
    assign op_valid = (cfg.op == OP_SUM) || (cfg.op == OP_MAX);

    // the cycle with done high stays idle and a held code restarts one edge later.
    assign start  = !busy && !done && op_valid;
    assign active = busy || start;
    assign last   = active && (level == n_levels - 1'b1);

    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            busy  <= 1'b0;
            level <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= last; // one-cycle pulse.
            if (last)
            begin
                busy  <= 1'b0;
                level <= '0;
            end
            else if (active)
            begin
                busy  <= 1'b1;
                level <= level + 1'b1;
            end
        end
    end

endmodule

//--- red_acc.sv
`timescale 1ns/10ps
`include "red_cfg.svh"

module red_acc (
    input  logic                       clk,
    input  logic                       nrst,
    input  red_pkg::red_cfg_t          cfg,
    input  logic [`RED_STEP_BITS-1:0]  level,
    input  logic                       last,
    input  red_pkg::red_work_t         first_word,
    input  red_pkg::red_work_t         next_word,
    input  logic [`RED_XLEN-1:0]       scalar,
    output red_pkg::red_work_t         work,
    output logic [`RED_XLEN-1:0]       result
);

    import red_pkg::*;

    red_work_t            work_d;
    logic [`RED_XLEN-1:0] elem0;
    logic [`RED_XLEN-1:0] merged;

    always_comb
    begin
        work_d = (level == '0) ? first_word : next_word;
        elem0  = red_sext(cfg.sew, work_d.w[0]); // element 0 lives in the low bits.

        // scalar goes first so that it wins a tie.
        merged = red_combine(cfg.op, red_sext(cfg.sew, scalar), elem0);
    end

    always_ff @(posedge clk)
    begin
        work <= work_d;
    end

    always_ff @(posedge clk)
    begin
        if (!nrst)
            result <= '0;
        else if (last)
            result <= red_zext(cfg.sew, merged); // upper bits zero.
    end

endmodule

//--- red_unit.sv
`timescale 1ns/10ps
`include "red_cfg.svh"

module red_unit (
    input  logic                  clk,
    input  logic                  nrst,
    input  red_pkg::red_cfg_t     cfg,
    input  red_pkg::red_src_t     src,
    input  logic [`RED_XLEN-1:0]  scalar,
    output logic                  done,
    output logic [`RED_XLEN-1:0]  result
);

    import red_pkg::*;

    logic [`RED_STEP_BITS-1:0] level;
    logic                      last;
    red_work_t                 first_word;
    red_work_t                 next_word;
    red_work_t                 work;

    red_seq i_red_seq (
        .clk   (clk),
        .nrst  (nrst),
        .cfg   (cfg),
        .level (level),
        .busy  (),      // only needed inside the sequencer.
        .last  (last),
        .done  (done)
    );

    // level 0 halves the full register group.
    red_tree_level #(
        .in_bits (`RED_VLEN*`RED_NREGS)
    ) i_tree_src (
        .cfg      (cfg),
        .level    (level),
        .word_in  (src),
        .word_out (first_word)
    );

    // later levels fold the working register.
    red_tree_level #(
        .in_bits (`RED_WORK_BITS)
    ) i_tree_work (
        .cfg      (cfg),
        .level    (level),
        .word_in  (work),
        .word_out (next_word)
    );

    red_acc i_red_acc (
        .clk        (clk),
        .nrst       (nrst),
        .cfg        (cfg),
        .level      (level),
        .last       (last),
        .first_word (first_word),
        .next_word  (next_word),
        .scalar     (scalar),
        .work       (work),
        .result     (result)
    );

endmodule

//--- red_assert.sv
`timescale 1ns/10ps
`include "red_cfg.svh"

module red_assert (
    input  logic                       clk,
    input  logic                       nrst,
    input  red_pkg::red_cfg_t          cfg,
    input  logic [`RED_STEP_BITS-1:0]  level,
    input  logic                       busy,
    input  logic                       done
);

    import red_pkg::*;

    int fail_count = 0;

    done_single: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
        else
        begin
            fail_count++;
            $error("done stayed high for two cycles");
        end

    // reset is synchronous so done clears one edge later.
    done_in_reset: assert property (@(posedge clk) !nrst |=> !done)
        else
        begin
            fail_count++;
            $error("done high while in reset");
        end

    level_range: assert property (@(posedge clk) disable iff (!nrst) level <= 3'd5)
        else
        begin
            fail_count++;
            $error("level index went past 5");
        end

    cfg_stable: assert property (@(posedge clk) disable iff (!nrst) busy |-> $stable(cfg))
        else
        begin
            fail_count++;
            $error("cfg changed during an operation");
        end

    no_reserved: assert property (@(posedge clk) disable iff (!nrst)
        busy |-> (cfg.sew inside {SEW_8, SEW_16, SEW_32}) &&
                 (cfg.lmul inside {LMUL_1, LMUL_2, LMUL_4}))
        else
        begin
            fail_count++;
            $error("reserved element width or group size while busy");
        end

endmodule

//--- tb_red.sv
`timescale 1ns/10ps
`include "red_cfg.svh"

module tb_red;

    import red_pkg::*;

    localparam int reset_cycles = 10;
    localparam int n_entries    = 20;
    localparam int max_wait     = 8;
    // at most 8 cycles per entry plus slack for reset and the idle checks.
    localparam int timeout_cycles = n_entries * max_wait + 20;

    localparam logic [1:0] pat_rand   = 2'd0;
    localparam logic [1:0] pat_ramp   = 2'd1;
    localparam logic [1:0] pat_neg    = 2'd2;
    localparam logic [1:0] pat_maxpos = 2'd3;

    typedef struct packed {
        red_cfg_t             cfg;
        logic [1:0]           pat;
        logic [`RED_XLEN-1:0] scalar;
    } stim_t;

    logic                 clk = 1'b0;
    logic                 nrst;
    red_cfg_t             cfg;
    red_src_t             src;
    logic [`RED_XLEN-1:0] scalar;
    logic                 done;
    logic [`RED_XLEN-1:0] result;

    stim_t  stim [n_entries];
    integer seed;
    int     cycle_count  = 0;
    int     result_errs  = 0;
    int     latency_errs = 0;
    int     done_errs    = 0;
    int     other_errs   = 0;
    int     assert_errs  = 0;

    red_unit i_red_unit (
        .clk    (clk),
        .nrst   (nrst),
        .cfg    (cfg),
        .src    (src),
        .scalar (scalar),
        .done   (done),
        .result (result)
    );

    bind red_seq red_assert i_red_assert (
        .clk   (clk),
        .nrst  (nrst),
        .cfg   (cfg),
        .level (level),
        .busy  (busy),
        .done  (done)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic stim_t make_entry(input red_op_e op, input red_sew_e sew,
                                         input red_lmul_e lmul, input logic [1:0] pat,
                                         input logic [`RED_XLEN-1:0] sc);
        stim_t e;
        e.cfg.op   = op;
        e.cfg.sew  = sew;
        e.cfg.lmul = lmul;
        e.pat      = pat;
        e.scalar   = sc;
        return e;
    endfunction

    function automatic int elem_bits(input red_cfg_t c);
        return 8 << c.sew;
    endfunction

    function automatic int elem_count(input red_cfg_t c);
        return (`RED_VLEN / elem_bits(c)) << c.lmul;
    endfunction

    // low w bits of x as a signed number.
    function automatic longint as_signed(input logic [`RED_XLEN-1:0] x, input int w);
        longint v;
        longint span;
        span = longint'(1) << w;
        v = longint'({32'd0, x}) & (span - 1);
        if (v >= (span >> 1))
            v = v - span;
        return v;
    endfunction

    function automatic logic [`RED_XLEN-1:0] expected_result(input red_cfg_t c,
                                                             input red_src_t s,
                                                             input logic [`RED_XLEN-1:0] sc);
        logic [511:0] raw;
        logic [511:0] shifted;
        longint       acc;
        longint       e;
        longint       low;
        int           w;
        w = elem_bits(c);
        raw = s;
        acc = as_signed(sc, w);
        for (int j = 0; j < elem_count(c); j++)
        begin
            shifted = raw >> (w * j);
            e = as_signed(shifted[31:0], w);
            if (c.op == OP_SUM)
                acc = acc + e;
            else if (e > acc)
                acc = e;
        end
        low = acc & ((longint'(1) << w) - 1); // zero-extended.
        return low[31:0];
    endfunction

    function automatic int expected_latency(input red_cfg_t c);
        int lat;
        lat = 0;
        while ((1 << lat) < elem_count(c))
            lat++;
        return lat;
    endfunction

    task automatic build_src(input stim_t e, output red_src_t s);
        logic [511:0] raw;
        logic [511:0] mask;
        logic [511:0] val;
        int           w;
        w = elem_bits(e.cfg);
        for (int k = 0; k < 16; k++)
            raw[32*k +: 32] = $random(seed); // registers outside the group stay random.
        if (e.pat != pat_rand)
        begin
            mask = (512'd1 << w) - 512'd1;
            for (int j = 0; j < elem_count(e.cfg); j++)
            begin
                case (e.pat)
                    pat_ramp: val = 512'(j + 1);
                    pat_neg:  val = {512{1'b1}} - 512'(j + 1);
                    default:  val = mask >> 1; // largest positive element.
                endcase
                raw = (raw & ~(mask << (w * j))) | ((val & mask) << (w * j));
            end
        end
        s = raw;
    endtask

    task automatic build_table();
        stim[0]  = make_entry(OP_SUM, SEW_8,  LMUL_1, pat_ramp,   32'h0000_0005);
        stim[1]  = make_entry(OP_SUM, SEW_8,  LMUL_2, pat_rand,   32'h1357_9bdf);
        stim[2]  = make_entry(OP_SUM, SEW_8,  LMUL_4, pat_rand,   32'hffff_ff01);
        stim[3]  = make_entry(OP_SUM, SEW_16, LMUL_1, pat_rand,   32'h0000_8001);
        stim[4]  = make_entry(OP_SUM, SEW_16, LMUL_2, pat_ramp,   32'h1234_0010);
        stim[5]  = make_entry(OP_SUM, SEW_16, LMUL_4, pat_rand,   32'hdead_beef);
        stim[6]  = make_entry(OP_SUM, SEW_32, LMUL_1, pat_rand,   32'h0000_0000);
        stim[7]  = make_entry(OP_SUM, SEW_32, LMUL_2, pat_rand,   32'h8000_0001);
        stim[8]  = make_entry(OP_SUM, SEW_32, LMUL_4, pat_maxpos, 32'h0000_0001);
        stim[9]  = make_entry(OP_SUM, SEW_8,  LMUL_4, pat_maxpos, 32'h0000_0080);
        stim[10] = make_entry(OP_MAX, SEW_8,  LMUL_1, pat_rand,   32'h0000_0000);
        stim[11] = make_entry(OP_MAX, SEW_8,  LMUL_4, pat_neg,    32'hffff_ff80);
        stim[12] = make_entry(OP_MAX, SEW_8,  LMUL_2, pat_neg,    32'h0000_0003);
        stim[13] = make_entry(OP_MAX, SEW_16, LMUL_1, pat_neg,    32'h0000_7fff);
        stim[14] = make_entry(OP_MAX, SEW_16, LMUL_2, pat_rand,   32'hffff_8000);
        stim[15] = make_entry(OP_MAX, SEW_16, LMUL_4, pat_rand,   32'h0000_0100);
        stim[16] = make_entry(OP_MAX, SEW_32, LMUL_1, pat_neg,    32'h8000_0000);
        stim[17] = make_entry(OP_MAX, SEW_32, LMUL_2, pat_rand,   32'h7000_0000);
        stim[18] = make_entry(OP_MAX, SEW_32, LMUL_4, pat_maxpos, 32'h7fff_ffff);
        stim[19] = make_entry(OP_MAX, SEW_8,  LMUL_2, pat_ramp,   32'hffff_ff00);
    endtask

    task automatic check_result(input string name, input logic [`RED_XLEN-1:0] exp,
                                input logic [`RED_XLEN-1:0] act);
        if (act !== exp)
        begin
            result_errs++;
            $display("ERR %0t %s exp %h act %h", $time, name, exp, act);
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (act != exp)
        begin
            latency_errs++;
            $display("ERR %0t latency exp %0d act %0d", $time, exp, act);
        end
    endtask

    task automatic check_done(input logic exp, input logic act);
        if (act !== exp)
        begin
            done_errs++;
            $display("ERR %0t done exp %b act %b", $time, exp, act);
        end
    endtask

    task automatic check_idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            @(negedge clk);
            check_done(1'b0, done);
            check_result("result", '0, result);
        end
    endtask

    task automatic run_entry(input int idx);
        stim_t                e;
        red_src_t             s;
        logic [`RED_XLEN-1:0] exp;
        int                   cycles;
        e = stim[idx];
        build_src(e, s);
        exp = expected_result(e.cfg, s, e.scalar);
        @(posedge clk);
        cfg    <= e.cfg;
        src    <= s;
        scalar <= e.scalar;
        cycles = 0;
        while (!done && cycles < max_wait)
        begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        if (!done)
        begin
            other_errs++;
            $display("entry %0d never raised done within %0d cycles", idx, max_wait);
        end
        else
        begin
            check_latency(expected_latency(e.cfg), cycles);
            check_result("result", exp, result);
        end
        @(posedge clk);
        cfg.op <= OP_IDLE;
        @(negedge clk);
        check_done(1'b0, done);
        check_result("result", exp, result); // held after the pulse.
    endtask

    // reset lands two levels into a six-level sum.
    task automatic reset_mid_op();
        stim_t    e;
        red_src_t s;
        e = make_entry(OP_SUM, SEW_8, LMUL_4, pat_rand, 32'h0000_0011);
        build_src(e, s);
        @(posedge clk);
        cfg    <= e.cfg;
        src    <= s;
        scalar <= e.scalar;
        repeat (2) @(posedge clk);
        nrst   <= 1'b0;
        cfg.op <= OP_IDLE;
        // runs past the edge where done would have risen.
        repeat (4)
        begin
            @(posedge clk);
            @(negedge clk);
            check_done(1'b0, done);
        end
        @(posedge clk);
        nrst <= 1'b1;
        check_idle(4);
    endtask

    initial
    begin
        seed     = 94968;
        nrst     <= 1'b0;
        cfg.op   <= OP_IDLE;
        cfg.sew  <= SEW_8;
        cfg.lmul <= LMUL_1;
        src      <= '0;
        scalar   <= '0;
        build_table();
        repeat (reset_cycles) @(posedge clk);
        nrst <= 1'b1;
        check_idle(4);
        for (int i = 0; i < n_entries; i++)
            run_entry(i);
        reset_mid_op();
        assert_errs = i_red_unit.i_red_seq.i_red_assert.fail_count;
        $display("errors: result %0d, latency %0d, done %0d, other %0d, assertion %0d",
                 result_errs, latency_errs, done_errs, other_errs, assert_errs);
        if (result_errs + latency_errs + done_errs + other_errs + assert_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
red_pkg.sv
red_tree_level.sv
red_seq.sv
red_acc.sv
red_unit.sv
red_assert.sv
tb_red.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
TOP      = tb_red
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

SRCS = $(shell grep -v '^+' $(FILELIST)) red_cfg.svh
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'TEST PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
